// File: source/ncpu32k_pkg.sv
// Shared constants for the interrupt and machine-state block
// Imported by wildcard in each RTL module header

package ncpu32k_pkg;

   // Machine word width
   localparam int unsigned ncpu_dw = 32;

   // Number of interrupt lines
   // Must not exceed the word width
   localparam int unsigned ncpu_nirq = 32;

   // Register address width
   localparam int unsigned msr_addr_w = 4;

   // Register map
   localparam logic [msr_addr_w-1:0] msr_addr_psr  = msr_addr_w'(0);
   localparam logic [msr_addr_w-1:0] msr_addr_epsr = msr_addr_w'(1);
   localparam logic [msr_addr_w-1:0] msr_addr_epc  = msr_addr_w'(2);
   localparam logic [msr_addr_w-1:0] msr_addr_imr  = msr_addr_w'(3);
   // IRR is read only
   localparam logic [msr_addr_w-1:0] msr_addr_irr  = msr_addr_w'(4);

   // Implemented PSR bits
   // Upper bits read back as zero
   localparam int unsigned psr_w = 8;

   // Interrupt enable
   localparam int unsigned psr_ire_bit = 0;
   // Kernel mode
   localparam int unsigned psr_rm_bit = 1;

   // Out of reset
   // Interrupts off and kernel mode on
   localparam logic [psr_w-1:0] psr_reset = psr_w'(1 << psr_rm_bit);

   // Interrupt handler entry address
   localparam logic [ncpu_dw-1:0] irq_vector = 32'h0000_0100;

endpackage

// File: source/ncpu32k_irqc.sv
// Interrupt controller with level synchroniser and mask register
// Produces the gated request used by the entry unit

module ncpu32k_irqc
   import ncpu32k_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   // Level interrupts
   // May be asynchronous
   input  logic [ncpu_nirq-1:0] irqs_lvl,
   input  logic                 psr_ire,
   // Mask write port from the MSR file
   input  logic                 imr_we,
   input  logic [ncpu_dw-1:0]   imr_nxt,
   output logic [ncpu_dw-1:0]   imr,
   output logic [ncpu_dw-1:0]   irr,
   output logic                 irq_sync
);

   logic [ncpu_nirq-1:0] irr_s0;
   logic [ncpu_nirq-1:0] irr_s1;
   logic [ncpu_dw-1:0]   imr_q;
   logic [ncpu_nirq-1:0] irq_masked;

   // Two flop synchroniser
   // Line change shows in irr after two edges
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         irr_s0 <= '0;
         irr_s1 <= '0;
      end else begin
         irr_s0 <= irqs_lvl;
         irr_s1 <= irr_s0;
      end
   end

   // Mask register
   // All lines masked out of reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         imr_q <= '1;
      end else if (imr_we) begin
         imr_q <= imr_nxt;
      end
   end

   // Bypass so a mask write counts this cycle
   assign imr = imr_we ? imr_nxt : imr_q;

   // Zero extend pending lines to word width
   assign irr = ncpu_dw'(irr_s1);

   // Pending and unmasked
   assign irq_masked = irr_s1 & ~imr[ncpu_nirq-1:0];

   // Gate with global enable
   assign irq_sync = (|irq_masked) & psr_ire;

endmodule

// File: source/ncpu32k_msr_file.sv
// Machine-state registers PSR, EPSR and EPC with the register read mux
// Applies interrupt entry and return updates from the entry unit
// Routes IMR writes to the interrupt controller

module ncpu32k_msr_file
   import ncpu32k_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   // Register access from the core
   input  logic [msr_addr_w-1:0] msr_addr,
   input  logic [ncpu_dw-1:0]    msr_wdat,
   input  logic                  msr_we,
   output logic [ncpu_dw-1:0]    msr_rdat,
   // IMR and IRR live in the irqc
   output logic                  imr_we,
   output logic [ncpu_dw-1:0]    imr_nxt,
   input  logic [ncpu_dw-1:0]    imr,
   input  logic [ncpu_dw-1:0]    irr,
   // Entry and return strobes
   input  logic                  take_irq,
   input  logic                  take_eret,
   input  logic [ncpu_dw-1:0]    commit_npc,
   output logic                  psr_ire,
   output logic [ncpu_dw-1:0]    epc
);

   logic [psr_w-1:0]   psr_q;
   logic [psr_w-1:0]   epsr_q;
   logic [ncpu_dw-1:0] epc_q;

   logic               psr_we;
   logic               epsr_we;
   logic               epc_we;
   logic [psr_w-1:0]   psr_entry;

   // Write decode
   assign psr_we  = msr_we && (msr_addr == msr_addr_psr);
   assign epsr_we = msr_we && (msr_addr == msr_addr_epsr);
   assign epc_we  = msr_we && (msr_addr == msr_addr_epc);

   // IMR write goes straight through
   // Not blocked by an entry in the same cycle
   assign imr_we  = msr_we && (msr_addr == msr_addr_imr);
   assign imr_nxt = msr_wdat;

   // PSR seen by the handler
   // Interrupts off and kernel mode on
   always_comb begin
      psr_entry = psr_q;
      psr_entry[psr_ire_bit] = 1'b0;
      psr_entry[psr_rm_bit]  = 1'b1;
   end

   // PSR
   // Entry and return take priority over a write
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         psr_q <= psr_reset;
      end else if (take_irq) begin
         psr_q <= psr_entry;
      end else if (take_eret) begin
         // Restore saved status
         psr_q <= epsr_q;
      end else if (psr_we) begin
         psr_q <= msr_wdat[psr_w-1:0];
      end
   end

   // EPSR
   // Saves PSR on entry
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         epsr_q <= '0;
      end else if (take_irq) begin
         epsr_q <= psr_q;
      end else if (epsr_we) begin
         epsr_q <= msr_wdat[psr_w-1:0];
      end
   end

   // EPC
   // Return address is the next instruction at the boundary
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         epc_q <= '0;
      end else if (take_irq) begin
         epc_q <= commit_npc;
      end else if (epc_we) begin
         epc_q <= msr_wdat;
      end
   end

   assign psr_ire = psr_q[psr_ire_bit];
   assign epc     = epc_q;

   // Read mux
   // Unmapped addresses read zero
   always_comb begin
      case (msr_addr)
         msr_addr_psr:  msr_rdat = ncpu_dw'(psr_q);
         msr_addr_epsr: msr_rdat = ncpu_dw'(epsr_q);
         msr_addr_epc:  msr_rdat = epc_q;
         // Bypassed mask from the irqc
         msr_addr_imr:  msr_rdat = imr;
         msr_addr_irr:  msr_rdat = irr;
         default:       msr_rdat = '0;
      endcase
   end

endmodule

// File: source/ncpu32k_irq_entry.sv
// Interrupt entry and exception return control
// Decides at each reported boundary and drives the registered redirect

module ncpu32k_irq_entry
   import ncpu32k_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   // Instruction boundary from the core
   input  logic               commit_valid,
   // Return instruction
   input  logic               eret_valid,
   // Gated request from the irqc
   input  logic               irq_sync,
   // Return target held in the MSR file
   input  logic [ncpu_dw-1:0] epc,
   // Update strobes to the MSR file
   output logic               take_irq,
   output logic               take_eret,
   // Redirect to the fetch stage
   output logic               exc_flush,
   output logic [ncpu_dw-1:0] exc_target
);

   logic               flush_nxt;
   logic [ncpu_dw-1:0] target_nxt;

   // Take only at a boundary
   // An eret in the same cycle blocks the interrupt
   assign take_irq = commit_valid & irq_sync & ~eret_valid;

   // Return is always honoured
   assign take_eret = eret_valid;

   // Either event redirects the core
   assign flush_nxt = take_irq | take_eret;

   // Redirect address
   // EPC is sampled before the MSR file updates it
   always_comb begin
      if (take_irq) begin
         target_nxt = irq_vector;
      end else begin
         target_nxt = epc;
      end
   end

   // One cycle flush pulse
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         exc_flush <= 1'b0;
      end else begin
         exc_flush <= flush_nxt;
      end
   end

   // Target only loads with a flush
   // Holds its value otherwise
   always_ff @(posedge clk) begin
      if (flush_nxt) begin
         exc_target <= target_nxt;
      end
   end

endmodule

// File: source/ncpu32k_irq_subsys.sv
// Top level of the interrupt and machine-state block
// Wires the irqc, the MSR file and the entry unit together

module ncpu32k_irq_subsys
   import ncpu32k_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   // Asynchronous interrupt levels
   input  logic [ncpu_nirq-1:0]  irqs_lvl,
   // Register access
   input  logic [msr_addr_w-1:0] msr_addr,
   input  logic [ncpu_dw-1:0]    msr_wdat,
   input  logic                  msr_we,
   output logic [ncpu_dw-1:0]    msr_rdat,
   // Boundary and return strobes
   input  logic                  commit_valid,
   input  logic [ncpu_dw-1:0]    commit_npc,
   input  logic                  eret_valid,
   // Status and redirect
   output logic                  irq_sync,
   output logic                  exc_flush,
   output logic [ncpu_dw-1:0]    exc_target
);

   // Mask write path
   logic               imr_we;
   logic [ncpu_dw-1:0] imr_nxt;
   // Readback from the irqc
   logic [ncpu_dw-1:0] imr;
   logic [ncpu_dw-1:0] irr;
   // Global enable from PSR
   logic               psr_ire;
   // Entry unit to MSR file
   logic               take_irq;
   logic               take_eret;
   logic [ncpu_dw-1:0] epc;

   // Synchroniser and mask
   ncpu32k_irqc irqc_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .irqs_lvl  (irqs_lvl),
      .psr_ire   (psr_ire),
      .imr_we    (imr_we),
      .imr_nxt   (imr_nxt),
      .imr       (imr),
      .irr       (irr),
      .irq_sync  (irq_sync)
   );

   // Status registers and read port
   ncpu32k_msr_file msr_file_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .msr_addr   (msr_addr),
      .msr_wdat   (msr_wdat),
      .msr_we     (msr_we),
      .msr_rdat   (msr_rdat),
      .imr_we     (imr_we),
      .imr_nxt    (imr_nxt),
      .imr        (imr),
      .irr        (irr),
      .take_irq   (take_irq),
      .take_eret  (take_eret),
      .commit_npc (commit_npc),
      .psr_ire    (psr_ire),
      .epc        (epc)
   );

   // Take decision and redirect
   ncpu32k_irq_entry irq_entry_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .commit_valid (commit_valid),
      .eret_valid   (eret_valid),
      .irq_sync     (irq_sync),
      .epc          (epc),
      .take_irq     (take_irq),
      .take_eret    (take_eret),
      .exc_flush    (exc_flush),
      .exc_target   (exc_target)
   );

endmodule

// File: tests/tb_clk_gen.sv
// Free running clock for the testbench
// Period of 4 time units and starts low

module tb_clk_gen (
   output logic clk
);

   // Half of the 4 unit period
   localparam int half_period = 2;

   initial begin
      clk = 1'b0;
      forever begin
         #half_period clk = ~clk;
      end
   end

endmodule

// File: tests/tb_irq_subsys.sv
// Testbench for the interrupt and machine-state block
// Directed checks first and then seeded random traffic against a cycle model

module tb_irq_subsys
   import ncpu32k_pkg::*;
();

   localparam int unsigned reset_cycles  = 16;
   localparam int unsigned random_cycles = 3000;
   localparam int unsigned flush_timeout = 8;
   localparam int unsigned run_limit     = 20000;

   logic                  clk;
   logic                  rst_n;
   logic [ncpu_nirq-1:0]  irqs_lvl;
   logic [msr_addr_w-1:0] msr_addr;
   logic [ncpu_dw-1:0]    msr_wdat;
   logic                  msr_we;
   logic [ncpu_dw-1:0]    msr_rdat;
   logic                  commit_valid;
   logic [ncpu_dw-1:0]    commit_npc;
   logic                  eret_valid;
   logic                  irq_sync;
   logic                  exc_flush;
   logic [ncpu_dw-1:0]    exc_target;

   // Next stimulus set by the sequences
   logic                  nx_rst_n;
   logic [ncpu_nirq-1:0]  nx_lvl;
   logic [msr_addr_w-1:0] nx_addr;
   logic [ncpu_dw-1:0]    nx_wdat;
   logic                  nx_we;
   logic                  nx_commit;
   logic [ncpu_dw-1:0]    nx_npc;
   logic                  nx_eret;

   // Stimulus the DUT sees this cycle
   logic                  cur_rst_n;
   logic [ncpu_nirq-1:0]  cur_lvl;
   logic [msr_addr_w-1:0] cur_addr;
   logic [ncpu_dw-1:0]    cur_wdat;
   logic                  cur_we;
   logic                  cur_commit;
   logic [ncpu_dw-1:0]    cur_npc;
   logic                  cur_eret;

   // Reference model state
   logic [ncpu_nirq-1:0]  m_s0;
   logic [ncpu_nirq-1:0]  m_s1;
   logic [ncpu_dw-1:0]    m_imr;
   logic [psr_w-1:0]      m_psr;
   logic [psr_w-1:0]      m_epsr;
   logic [ncpu_dw-1:0]    m_epc;
   logic                  m_flush;
   logic [ncpu_dw-1:0]    m_target;

   int                    seed;
   int                    errors;
   int                    checks;
   int unsigned           op;

   tb_clk_gen clk_gen_inst (
      .clk (clk)
   );

   ncpu32k_irq_subsys ncpu32k_irq_subsys_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .irqs_lvl     (irqs_lvl),
      .msr_addr     (msr_addr),
      .msr_wdat     (msr_wdat),
      .msr_we       (msr_we),
      .msr_rdat     (msr_rdat),
      .commit_valid (commit_valid),
      .commit_npc   (commit_npc),
      .eret_valid   (eret_valid),
      .irq_sync     (irq_sync),
      .exc_flush    (exc_flush),
      .exc_target   (exc_target)
   );

   task automatic check_word(input logic [ncpu_dw-1:0] got, input logic [ncpu_dw-1:0] exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   // Mask as the irqc presents it
   // A write counts at once
   function automatic logic [ncpu_dw-1:0] bypass_imr();
      if (cur_we && cur_addr == msr_addr_imr) begin
         return cur_wdat;
      end
      return m_imr;
   endfunction

   function automatic logic model_irq();
      logic [ncpu_dw-1:0] mask;
      mask = bypass_imr();
      return (|(m_s1 & ~mask[ncpu_nirq-1:0])) & m_psr[psr_ire_bit];
   endfunction

   function automatic logic [ncpu_dw-1:0] model_rdat(input logic [msr_addr_w-1:0] addr);
      case (addr)
         msr_addr_psr:  return ncpu_dw'(m_psr);
         msr_addr_epsr: return ncpu_dw'(m_epsr);
         msr_addr_epc:  return m_epc;
         msr_addr_imr:  return bypass_imr();
         msr_addr_irr:  return ncpu_dw'(m_s1);
         default:       return '0;
      endcase
   endfunction

   // State update at the rising edge from the inputs of the closing cycle
   task automatic advance_model();
      logic             take;
      logic [psr_w-1:0] old_psr;
      logic [psr_w-1:0] old_epsr;
      take     = cur_commit & model_irq() & ~cur_eret;
      old_psr  = m_psr;
      old_epsr = m_epsr;
      if (!cur_rst_n) begin
         m_s0    = '0;
         m_s1    = '0;
         m_imr   = '1;
         m_psr   = psr_reset;
         m_epsr  = '0;
         m_epc   = '0;
         m_flush = 1'b0;
      end else begin
         m_flush = take | cur_eret;
         // Target uses EPC before this edge
         if (take) begin
            m_target = irq_vector;
         end else if (cur_eret) begin
            m_target = m_epc;
         end
         if (take) begin
            m_psr = old_psr;
            m_psr[psr_ire_bit] = 1'b0;
            m_psr[psr_rm_bit]  = 1'b1;
         end else if (cur_eret) begin
            m_psr = old_epsr;
         end else if (cur_we && cur_addr == msr_addr_psr) begin
            m_psr = cur_wdat[psr_w-1:0];
         end
         if (take) begin
            m_epsr = old_psr;
         end else if (cur_we && cur_addr == msr_addr_epsr) begin
            m_epsr = cur_wdat[psr_w-1:0];
         end
         if (take) begin
            m_epc = cur_npc;
         end else if (cur_we && cur_addr == msr_addr_epc) begin
            m_epc = cur_wdat;
         end
         // IMR write is never blocked by an entry
         if (cur_we && cur_addr == msr_addr_imr) begin
            m_imr = cur_wdat;
         end
         m_s1 = m_s0;
         m_s0 = cur_lvl;
      end
   endtask

   task automatic check_outputs();
      check_bit(irq_sync, model_irq(), "irq_sync");
      check_word(msr_rdat, model_rdat(cur_addr), "msr_rdat");
      check_bit(exc_flush, m_flush, "exc_flush");
      if (m_flush) begin
         check_word(exc_target, m_target, "exc_target");
      end
   endtask

   // One clock of model update and input drive
   // Outputs checked at the falling edge
   task automatic run_cycle();
      @(posedge clk);
      advance_model();
      rst_n        <= nx_rst_n;
      irqs_lvl     <= nx_lvl;
      msr_addr     <= nx_addr;
      msr_wdat     <= nx_wdat;
      msr_we       <= nx_we;
      commit_valid <= nx_commit;
      commit_npc   <= nx_npc;
      eret_valid   <= nx_eret;
      cur_rst_n  = nx_rst_n;
      cur_lvl    = nx_lvl;
      cur_addr   = nx_addr;
      cur_wdat   = nx_wdat;
      cur_we     = nx_we;
      cur_commit = nx_commit;
      cur_npc    = nx_npc;
      cur_eret   = nx_eret;
      @(negedge clk);
      check_outputs();
   endtask

   // No strobes and IRR on the read port
   task automatic idle_inputs();
      nx_we     = 1'b0;
      nx_commit = 1'b0;
      nx_eret   = 1'b0;
      nx_addr   = msr_addr_irr;
   endtask

   task automatic write_reg(input logic [msr_addr_w-1:0] addr, input logic [ncpu_dw-1:0] data);
      idle_inputs();
      nx_we   = 1'b1;
      nx_addr = addr;
      nx_wdat = data;
      run_cycle();
   endtask

   task automatic read_reg(input logic [msr_addr_w-1:0] addr, input logic [ncpu_dw-1:0] exp,
                           input string what);
      idle_inputs();
      nx_addr = addr;
      run_cycle();
      check_word(msr_rdat, exp, what);
   endtask

   // Counted wait for the redirect pulse
   // Expected one cycle after the strobe
   task automatic wait_flush(input logic [ncpu_dw-1:0] exp_target, input string what);
      int unsigned n;
      n = 0;
      idle_inputs();
      do begin
         run_cycle();
         n++;
      end while (exc_flush !== 1'b1 && n < flush_timeout);
      if (exc_flush !== 1'b1) begin
         errors++;
         $display("Timed out after %0d cycles waiting for exc_flush in %s", n, what);
      end else begin
         check_word(n, 1, {what, " latency"});
         check_word(exc_target, exp_target, {what, " target"});
      end
   endtask

   // Stop a stuck run
   initial begin
      for (int i = 0; i < run_limit; i++) begin
         @(posedge clk);
      end
      $display("Simulation did not finish within %0d cycles", run_limit);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      seed   = 39;
      errors = 0;
      checks = 0;
      rst_n        = 1'b0;
      irqs_lvl     = '0;
      msr_addr     = '0;
      msr_wdat     = '0;
      msr_we       = 1'b0;
      commit_valid = 1'b0;
      commit_npc   = '0;
      eret_valid   = 1'b0;
      nx_rst_n = 1'b0;
      nx_lvl   = '0;
      nx_wdat  = '0;
      nx_npc   = '0;
      idle_inputs();
      nx_addr    = '0;
      cur_rst_n  = 1'b0;
      cur_lvl    = '0;
      cur_addr   = '0;
      cur_wdat   = '0;
      cur_we     = 1'b0;
      cur_commit = 1'b0;
      cur_npc    = '0;
      cur_eret   = 1'b0;
      m_target   = '0;

      // Reset low for 16 edges
      // Released on the last one
      for (int i = 0; i < reset_cycles; i++) begin
         if (i == reset_cycles - 1) begin
            nx_rst_n = 1'b1;
         end
         run_cycle();
      end

      // Reset values
      read_reg(msr_addr_imr, '1, "imr after reset");
      read_reg(msr_addr_irr, '0, "irr after reset");
      read_reg(msr_addr_psr, ncpu_dw'(psr_reset), "psr after reset");
      check_bit(irq_sync, 1'b0, "irq_sync after reset");

      // Line 3 pending with IRE on
      // Still masked
      nx_lvl = 32'h0000_0008;
      write_reg(msr_addr_psr, 32'h0000_0003);
      idle_inputs();
      run_cycle();
      read_reg(msr_addr_irr, 32'h0000_0008, "irr after sync");
      check_bit(irq_sync, 1'b0, "irq_sync while masked");

      // Unmask counts in the write cycle
      write_reg(msr_addr_imr, ~32'h0000_0008);
      check_bit(irq_sync, 1'b1, "irq_sync on mask write");

      // Interrupt entry at a boundary
      idle_inputs();
      nx_commit = 1'b1;
      nx_npc    = 32'h0000_1234;
      run_cycle();
      wait_flush(irq_vector, "irq entry");
      read_reg(msr_addr_epc, 32'h0000_1234, "epc after entry");
      read_reg(msr_addr_epsr, 32'h0000_0003, "epsr after entry");
      read_reg(msr_addr_psr, 32'h0000_0002, "psr after entry");

      // IRE now off so a commit gives no flush
      idle_inputs();
      nx_commit = 1'b1;
      run_cycle();
      idle_inputs();
      run_cycle();
      check_bit(exc_flush, 1'b0, "flush without irq_sync");

      // Return restores PSR from EPSR
      idle_inputs();
      nx_eret = 1'b1;
      run_cycle();
      wait_flush(32'h0000_1234, "eret");
      read_reg(msr_addr_psr, 32'h0000_0003, "psr after eret");

      // Eret with a commit and a pending interrupt
      idle_inputs();
      nx_commit = 1'b1;
      nx_eret   = 1'b1;
      nx_npc    = 32'h0000_5678;
      run_cycle();
      wait_flush(32'h0000_1234, "eret with commit");
      read_reg(msr_addr_epc, 32'h0000_1234, "epc after eret with commit");

      // Widths of the status registers
      write_reg(msr_addr_psr, 32'hffff_ffff);
      read_reg(msr_addr_psr, 32'h0000_00ff, "psr width");
      write_reg(msr_addr_epsr, 32'hffff_ffff);
      read_reg(msr_addr_epsr, 32'h0000_00ff, "epsr width");
      write_reg(msr_addr_epc, 32'hcafe_f00d);
      read_reg(msr_addr_epc, 32'hcafe_f00d, "epc write");
      write_reg(msr_addr_w'(9), 32'h1234_5678);
      read_reg(msr_addr_w'(9), '0, "unmapped read");

      // Entry wins over an EPC write
      idle_inputs();
      nx_we     = 1'b1;
      nx_addr   = msr_addr_epc;
      nx_wdat   = 32'hdead_beef;
      nx_commit = 1'b1;
      nx_npc    = 32'h0000_2000;
      run_cycle();
      wait_flush(irq_vector, "entry over write");
      read_reg(msr_addr_epc, 32'h0000_2000, "epc entry over write");
      read_reg(msr_addr_psr, 32'h0000_00fe, "psr entry over write");

      // Random traffic
      for (int i = 0; i < random_cycles; i++) begin
         idle_inputs();
         op = $unsigned($random(seed)) % 5;
         if ($unsigned($random(seed)) % 8 == 0) begin
            nx_lvl = $random(seed);
         end
         case (op)
            0: begin
               nx_we   = 1'b1;
               nx_addr = msr_addr_w'($unsigned($random(seed)) % 8);
               nx_wdat = $random(seed);
            end
            1: nx_addr = msr_addr_w'($unsigned($random(seed)) % 8);
            2: begin
               nx_commit = 1'b1;
               nx_npc    = $random(seed);
            end
            3: nx_eret = 1'b1;
            default: ;
         endcase
         run_cycle();
      end
      idle_inputs();
      run_cycle();

      $display("Checks: %0d errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: flist.f
source/ncpu32k_pkg.sv
source/ncpu32k_irqc.sv
source/ncpu32k_msr_file.sv
source/ncpu32k_irq_entry.sv
source/ncpu32k_irq_subsys.sv
tests/tb_clk_gen.sv
tests/tb_irq_subsys.sv

// File: Bender.yml
package:
  name: ncpu32k_irq_subsys

sources:
  # Package first, then leaf blocks, then the top level
  - source/ncpu32k_pkg.sv
  - source/ncpu32k_irqc.sv
  - source/ncpu32k_msr_file.sv
  - source/ncpu32k_irq_entry.sv
  - source/ncpu32k_irq_subsys.sv

  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_irq_subsys.sv
